/* logic/usb_settings.svh */
`ifndef USB_SETTINGS_SVH
`define USB_SETTINGS_SVH

// 48 MHz sampling of a 12 Mbit/s full-speed line
`define USB_OVERSAMPLE 4

// words between bit receiver and packet decoder
`define USB_FIFO_DEPTH 16

// largest payload the decoder counts, in bytes
`define USB_MAX_DATA 64

`endif

/* logic/usbLinePkg.sv */
`default_nettype none

package usbLinePkg;

    // differential pair state after the synchronizer
    typedef enum logic [1:0] {
        LINE_J   = 2'b00,
        LINE_K   = 2'b01,
        LINE_SE0 = 2'b10,
        LINE_SE1 = 2'b11
    } lineState_t;

    // kind of word in the receive stream
    typedef enum logic [1:0] {
        RX_DATA  = 2'b00,
        RX_END   = 2'b01,
        RX_ABORT = 2'b10
    } rxKind_t;

    // one received byte, bit 0 came first on the wire
    typedef logic [7:0] rxByte_t;

endpackage

`default_nettype wire

/* logic/usbPacketPkg.sv */
`default_nettype none

package usbPacketPkg;

    // low nibble of the pid byte, the high nibble repeats it inverted
    typedef logic [3:0] pid_t;

    // token group
    localparam pid_t PID_OUT   = 4'b0001;
    localparam pid_t PID_IN    = 4'b1001;
    localparam pid_t PID_SOF   = 4'b0101;
    localparam pid_t PID_SETUP = 4'b1101;
    // data group, DATA2 and MDATA are high speed only
    localparam pid_t PID_DATA0 = 4'b0011;
    localparam pid_t PID_DATA1 = 4'b1011;
    // handshake group
    localparam pid_t PID_ACK   = 4'b0010;
    localparam pid_t PID_NAK   = 4'b1010;
    localparam pid_t PID_STALL = 4'b1110;

    // token fields
    typedef logic [6:0] addr_t;
    typedef logic [3:0] endp_t;
    // sof carries address and endpoint bits as one number
    typedef logic [10:0] frame_t;

    // check registers
    typedef logic [4:0] crc5_t;
    typedef logic [15:0] crc16_t;

endpackage

`default_nettype wire

/* logic/usbDp.sv */
`default_nettype none

module usbDp (
    input  wire logic              CLK,
    input  wire logic              rst,
    input  wire logic              pinP,
    input  wire logic              pinN,
    output usbLinePkg::lineState_t lineState
);

    // two flops per pin, index 1 is the settled copy
    logic [1:0] syncP;
    logic [1:0] syncN;

    always_ff @(posedge CLK) begin
        if (rst) begin
            // start out as an idle J line
            syncP <= 2'b11;
            syncN <= 2'b00;
        end else begin
            syncP <= {syncP[0], pinP};
            syncN <= {syncN[0], pinN};
        end
    end

    // full speed: J is d+ high, K is d- high
    always_comb begin
        case ({syncP[1], syncN[1]})
            2'b10:   lineState = usbLinePkg::LINE_J;
            2'b01:   lineState = usbLinePkg::LINE_K;
            2'b00:   lineState = usbLinePkg::LINE_SE0;
            default: lineState = usbLinePkg::LINE_SE1;
        endcase
    end

endmodule

`default_nettype wire

/* logic/usbBitReceiver.sv */
`include "usb_settings.svh"
`default_nettype none

module usbBitReceiver (
    input  wire logic                   CLK,
    input  wire logic                   rst,
    input  wire usbLinePkg::lineState_t lineState,
    output logic                        wrEn,
    output usbLinePkg::rxKind_t         wrKind,
    output usbLinePkg::rxByte_t         wrByte
);

    typedef enum logic [1:0] {IDLE, SYNC, BYTES, SKIPIDLE} rxState_t;

    localparam int PHASE_W = $clog2(`USB_OVERSAMPLE);
    // sample two cycles after an edge, near the middle of the bit
    localparam logic [PHASE_W-1:0] SAMPLE_PHASE = 1;
    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(`USB_OVERSAMPLE - 1);
    // KJKJKJKK with K as 1, oldest sample in the msb
    localparam logic [7:0] SYNC_PATTERN = 8'b1010_1011;

    rxState_t state;
    logic [PHASE_W-1:0] phase;
    usbLinePkg::lineState_t lastLine;
    usbLinePkg::lineState_t prevSample;
    logic [7:0] syncHist;
    logic [7:0] syncNext;
    logic [2:0] onesCount;
    logic [2:0] bitCount;
    usbLinePkg::rxByte_t shiftReg;
    logic sampleNow;
    logic lineBit;
    logic lineSe;

    assign sampleNow = (phase == SAMPLE_PHASE);
    // nrzi: no change from the last bit is a 1
    assign lineBit = (lineState == prevSample);
    assign lineSe = (lineState == usbLinePkg::LINE_SE0) || (lineState == usbLinePkg::LINE_SE1);
    assign syncNext = {syncHist[6:0], lineState == usbLinePkg::LINE_K};

    // bit clock recovery, every edge restarts the phase
    always_ff @(posedge CLK) begin
        if (rst) begin
            phase <= '0;
            lastLine <= usbLinePkg::LINE_J;
        end else begin
            lastLine <= lineState;
            if (lineState != lastLine || phase == LAST_PHASE) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= IDLE;
            wrEn <= 1'b0;
            prevSample <= usbLinePkg::LINE_J;
            syncHist <= '0;
            onesCount <= '0;
            bitCount <= '0;
        end else begin
            wrEn <= 1'b0;
            if (sampleNow) begin
                prevSample <= lineState;
                case (state)
                    IDLE: begin
                        // first K of a possible sync
                        if (lineState == usbLinePkg::LINE_K) begin
                            syncHist <= 8'h01;
                            state <= SYNC;
                        end
                    end
                    SYNC: begin
                        syncHist <= syncNext;
                        if (lineSe) begin
                            state <= IDLE;
                        end else if (syncNext == SYNC_PATTERN) begin
                            // the closing KK is a 1 and counts towards stuffing
                            onesCount <= 3'd1;
                            bitCount <= '0;
                            state <= BYTES;
                        end
                    end
                    BYTES: begin
                        if (lineSe) begin
                            wrEn <= 1'b1;
                            // eop only on a byte boundary
                            if (lineState == usbLinePkg::LINE_SE0 && bitCount == 3'd0) begin
                                wrKind <= usbLinePkg::RX_END;
                                state <= IDLE;
                            end else begin
                                wrKind <= usbLinePkg::RX_ABORT;
                                state <= SKIPIDLE;
                            end
                        end else if (onesCount == 3'd6) begin
                            // stuffed zero is dropped, a seventh one is a bit error
                            onesCount <= '0;
                            if (lineBit) begin
                                wrEn <= 1'b1;
                                wrKind <= usbLinePkg::RX_ABORT;
                                state <= SKIPIDLE;
                            end
                        end else begin
                            shiftReg <= {lineBit, shiftReg[7:1]};
                            bitCount <= bitCount + 1'b1;
                            onesCount <= lineBit ? onesCount + 1'b1 : 3'd0;
                            if (bitCount == 3'd7) begin
                                wrEn <= 1'b1;
                                wrKind <= usbLinePkg::RX_DATA;
                                wrByte <= {lineBit, shiftReg[7:1]};
                            end
                        end
                    end
                    SKIPIDLE: begin
                        // the J that closes an eop
                        if (lineState == usbLinePkg::LINE_J && prevSample == usbLinePkg::LINE_SE0) begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/usbByteFifo.sv */
`include "usb_settings.svh"
`default_nettype none

module usbByteFifo (
    input  wire logic                CLK,
    input  wire logic                rst,
    input  wire logic                wrEn,
    input  wire usbLinePkg::rxKind_t wrKind,
    input  wire usbLinePkg::rxByte_t wrByte,
    input  wire logic                rdEn,
    output usbLinePkg::rxKind_t      rdKind,
    output usbLinePkg::rxByte_t      rdByte,
    output logic                     empty
);

    localparam int PTR_W = $clog2(`USB_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`USB_FIFO_DEPTH + 1);

    usbLinePkg::rxKind_t kindMem [`USB_FIFO_DEPTH];
    usbLinePkg::rxByte_t byteMem [`USB_FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic full;
    logic doWrite;
    logic doRead;

    assign full = (count == CNT_W'(`USB_FIFO_DEPTH));
    assign empty = (count == '0);
    // a word offered while full is lost
    assign doWrite = wrEn && !full;
    assign doRead = rdEn && !empty;
    // head word is always visible
    assign rdKind = kindMem[rdPtr];
    assign rdByte = byteMem[rdPtr];

    always_ff @(posedge CLK) begin
        if (doWrite) begin
            kindMem[wrPtr] <= wrKind;
            byteMem[wrPtr] <= wrByte;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge CLK) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/usbPacketDecoder.sv */
`include "usb_settings.svh"
`default_nettype none

module usbPacketDecoder (
    input  wire logic                CLK,
    input  wire logic                rst,
    input  wire usbLinePkg::rxKind_t rdKind,
    input  wire usbLinePkg::rxByte_t rdByte,
    input  wire logic                empty,
    output logic                     rdEn,
    output logic                     tokenValid,
    output usbPacketPkg::pid_t       tokenPid,
    output usbPacketPkg::addr_t      tokenAddr,
    output usbPacketPkg::endp_t      tokenEndp,
    output usbPacketPkg::frame_t     frameNumber,
    output logic                     handshakeValid,
    output usbPacketPkg::pid_t       handshakePid,
    output logic                     dataValid,
    output usbLinePkg::rxByte_t      dataByte,
    output logic                     dataEnd,
    output logic                     crcOk,
    output logic                     packetError
);

    typedef enum logic [2:0] {PID, TOKEN, DATA, HANDSHAKE, DRAIN} decState_t;

    // remainders once the crc field itself has been shifted through
    localparam usbPacketPkg::crc5_t CRC5_RESIDUAL = 5'b01100;
    localparam usbPacketPkg::crc16_t CRC16_RESIDUAL = 16'h800D;
    // payload plus crc16, the count sticks one above that
    localparam int COUNT_MAX = `USB_MAX_DATA + 3;
    localparam int COUNT_W = $clog2(COUNT_MAX + 1);

    decState_t state;
    logic [COUNT_W-1:0] byteCount;
    usbPacketPkg::pid_t curPid;
    usbPacketPkg::crc5_t crc5;
    usbPacketPkg::crc16_t crc16;
    // dly0 is the newest byte, dly1 the one before it
    usbLinePkg::rxByte_t dly0;
    usbLinePkg::rxByte_t dly1;
    logic popData;
    logic popEnd;
    logic popAbort;
    logic tokenGood;
    logic lengthOk;

    // x^5 + x^2 + 1, bits in wire order
    function automatic usbPacketPkg::crc5_t crc5Byte(input usbPacketPkg::crc5_t crcIn,
                                                      input usbLinePkg::rxByte_t data);
        usbPacketPkg::crc5_t crc;
        crc = crcIn;
        for (int i = 0; i < 8; i++) begin
            crc = {crc[3:0], 1'b0} ^ ((crc[4] ^ data[i]) ? 5'b00101 : 5'b00000);
        end
        return crc;
    endfunction

    // x^16 + x^15 + x^2 + 1
    function automatic usbPacketPkg::crc16_t crc16Byte(input usbPacketPkg::crc16_t crcIn,
                                                        input usbLinePkg::rxByte_t data);
        usbPacketPkg::crc16_t crc;
        crc = crcIn;
        for (int i = 0; i < 8; i++) begin
            crc = {crc[14:0], 1'b0} ^ ((crc[15] ^ data[i]) ? 16'h8005 : 16'h0000);
        end
        return crc;
    endfunction

    // head word is taken as soon as it shows
    assign rdEn = !empty;
    assign popData = rdEn && (rdKind == usbLinePkg::RX_DATA);
    assign popEnd = rdEn && (rdKind == usbLinePkg::RX_END);
    assign popAbort = rdEn && (rdKind == usbLinePkg::RX_ABORT);
    // token body is exactly addr, endp and crc5 in two bytes
    assign tokenGood = (byteCount == COUNT_W'(2)) && (crc5 == CRC5_RESIDUAL);
    assign lengthOk = (byteCount >= COUNT_W'(2)) && (byteCount < COUNT_W'(COUNT_MAX));

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= PID;
            byteCount <= '0;
            tokenValid <= 1'b0;
            handshakeValid <= 1'b0;
            dataValid <= 1'b0;
            dataEnd <= 1'b0;
            packetError <= 1'b0;
        end else begin
            tokenValid <= 1'b0;
            handshakeValid <= 1'b0;
            dataValid <= 1'b0;
            dataEnd <= 1'b0;
            packetError <= 1'b0;
            if (popAbort) begin
                // a data packet still gets its closing pulse
                packetError <= 1'b1;
                if (state == DATA) begin
                    dataEnd <= 1'b1;
                    crcOk <= 1'b0;
                end
                state <= PID;
            end else if (popEnd) begin
                state <= PID;
                case (state)
                    TOKEN: begin
                        if (tokenGood) begin
                            tokenValid <= 1'b1;
                            tokenPid <= curPid;
                            tokenAddr <= dly1[6:0];
                            tokenEndp <= {dly0[2:0], dly1[7]};
                            frameNumber <= {dly0[2:0], dly1};
                        end else begin
                            packetError <= 1'b1;
                        end
                    end
                    DATA: begin
                        dataEnd <= 1'b1;
                        crcOk <= lengthOk && (crc16 == CRC16_RESIDUAL);
                    end
                    HANDSHAKE: begin
                        if (byteCount == '0) begin
                            handshakeValid <= 1'b1;
                            handshakePid <= curPid;
                        end else begin
                            packetError <= 1'b1;
                        end
                    end
                    // empty packet or an already rejected pid
                    default: packetError <= 1'b1;
                endcase
            end else if (popData) begin
                if (state == PID) begin
                    curPid <= rdByte[3:0];
                    byteCount <= '0;
                    crc5 <= '1;
                    crc16 <= '1;
                    if (rdByte[7:4] != ~rdByte[3:0]) begin
                        state <= DRAIN;
                    end else begin
                        case (rdByte[3:0])
                            usbPacketPkg::PID_OUT,
                            usbPacketPkg::PID_IN,
                            usbPacketPkg::PID_SOF,
                            usbPacketPkg::PID_SETUP: state <= TOKEN;
                            usbPacketPkg::PID_DATA0,
                            usbPacketPkg::PID_DATA1: state <= DATA;
                            usbPacketPkg::PID_ACK,
                            usbPacketPkg::PID_NAK,
                            usbPacketPkg::PID_STALL: state <= HANDSHAKE;
                            // high speed and special pids
                            default: state <= DRAIN;
                        endcase
                    end
                end else begin
                    if (byteCount != COUNT_W'(COUNT_MAX)) begin
                        byteCount <= byteCount + 1'b1;
                    end
                    crc5 <= crc5Byte(crc5, rdByte);
                    crc16 <= crc16Byte(crc16, rdByte);
                    dly0 <= rdByte;
                    dly1 <= dly0;
                    // last two bytes stay behind as the crc16 field
                    if (state == DATA && byteCount >= COUNT_W'(2)) begin
                        dataValid <= 1'b1;
                        dataByte <= dly1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/usb.sv */
`default_nettype none

module usb (
    input  wire logic            CLK,
    inout  wire                  usbDn,
    inout  wire                  usbDp,
    output logic                 usbPullup,
    input  wire logic            rst,
    output logic                 tokenValid,
    output usbPacketPkg::pid_t   tokenPid,
    output usbPacketPkg::addr_t  tokenAddr,
    output usbPacketPkg::endp_t  tokenEndp,
    output usbPacketPkg::frame_t frameNumber,
    output logic                 handshakeValid,
    output usbPacketPkg::pid_t   handshakePid,
    output logic                 dataValid,
    output usbLinePkg::rxByte_t  dataByte,
    output logic                 dataEnd,
    output logic                 crcOk,
    output logic                 packetError
);

    usbLinePkg::lineState_t lineState;
    logic wrEn;
    usbLinePkg::rxKind_t wrKind;
    usbLinePkg::rxByte_t wrByte;
    logic rdEn;
    usbLinePkg::rxKind_t rdKind;
    usbLinePkg::rxByte_t rdByte;
    logic empty;

    // 1.5k to d+ announces a full-speed device
    assign usbPullup = 1'b1;

    // receive only, the data pins are never driven
    usbDp padBlock (
        .CLK(CLK),
        .rst(rst),
        .pinP(usbDp),
        .pinN(usbDn),
        .lineState(lineState)
    );

    usbBitReceiver bitReceiver (
        .CLK(CLK),
        .rst(rst),
        .lineState(lineState),
        .wrEn(wrEn),
        .wrKind(wrKind),
        .wrByte(wrByte)
    );

    usbByteFifo byteFifo (
        .CLK(CLK),
        .rst(rst),
        .wrEn(wrEn),
        .wrKind(wrKind),
        .wrByte(wrByte),
        .rdEn(rdEn),
        .rdKind(rdKind),
        .rdByte(rdByte),
        .empty(empty)
    );

    usbPacketDecoder packetDecoder (
        .CLK(CLK),
        .rst(rst),
        .rdKind(rdKind),
        .rdByte(rdByte),
        .empty(empty),
        .rdEn(rdEn),
        .tokenValid(tokenValid),
        .tokenPid(tokenPid),
        .tokenAddr(tokenAddr),
        .tokenEndp(tokenEndp),
        .frameNumber(frameNumber),
        .handshakeValid(handshakeValid),
        .handshakePid(handshakePid),
        .dataValid(dataValid),
        .dataByte(dataByte),
        .dataEnd(dataEnd),
        .crcOk(crcOk),
        .packetError(packetError)
    );

endmodule

`default_nettype wire

/* test/usbClock.sv */
`default_nettype none

module usbClock #(
    parameter int PERIOD = 40
) (
    output logic CLK
);

    // free running, first rising edge after half a period
    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2) CLK = ~CLK;
        end
    end

endmodule

`default_nettype wire

/* test/usbTb.sv */
`default_nettype none

module usbTb;

    // the whole sequence of 4-cycle bits runs under 4000 cycles
    localparam int CYCLE_LIMIT = 8000;
    // results trail the eop by a few tens of cycles
    localparam int RESULT_WAIT = 100;

    logic CLK;
    logic rst;
    logic dpDrive;
    logic dnDrive;
    wire dpLine;
    wire dnLine;
    logic usbPullup;
    logic tokenValid;
    usbPacketPkg::pid_t tokenPid;
    usbPacketPkg::addr_t tokenAddr;
    usbPacketPkg::endp_t tokenEndp;
    usbPacketPkg::frame_t frameNumber;
    logic handshakeValid;
    usbPacketPkg::pid_t handshakePid;
    logic dataValid;
    usbLinePkg::rxByte_t dataByte;
    logic dataEnd;
    logic crcOk;
    logic packetError;

    // host line model state where level 1 is J
    logic level;
    int onesRun;
    // token entries of the expected results hold {isSof, pid, 11-bit field}
    logic [15:0] tokQ[$];
    usbPacketPkg::pid_t hsQ[$];
    usbLinePkg::rxByte_t dataQ[$];
    logic endQ[$];
    int errPending;
    int errorCount;
    int testErrors;
    int testIndex;
    int testsOk;
    int testsBad;
    int cycleCount = 0;

    // only the host drives the pins
    assign dpLine = dpDrive;
    assign dnLine = dnDrive;

    usbClock #(.PERIOD(40)) clockGen (.CLK(CLK));

    usb DUT (
        .CLK(CLK),
        .usbDn(dnLine),
        .usbDp(dpLine),
        .usbPullup(usbPullup),
        .rst(rst),
        .tokenValid(tokenValid),
        .tokenPid(tokenPid),
        .tokenAddr(tokenAddr),
        .tokenEndp(tokenEndp),
        .frameNumber(frameNumber),
        .handshakeValid(handshakeValid),
        .handshakePid(handshakePid),
        .dataValid(dataValid),
        .dataByte(dataByte),
        .dataEnd(dataEnd),
        .crcOk(crcOk),
        .packetError(packetError)
    );

    task automatic compareField(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // one bit time on the pins changed just after a rising edge
    task automatic driveLine(input logic p, input logic n);
        @(posedge CLK);
        #5;
        dpDrive = p;
        dnDrive = n;
        repeat (3) @(posedge CLK);
    endtask

    // a 0 toggles the line in nrzi
    task automatic rawBit(input logic b);
        if (!b) begin
            level = !level;
        end
        driveLine(level, !level);
        onesRun = b ? onesRun + 1 : 0;
    endtask

    task automatic encodeByte(input logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            rawBit(b[i]);
            // stuffed zero after six ones
            if (onesRun == 6) begin
                rawBit(1'b0);
            end
        end
    endtask

    // KJKJKJKK where the last K counts as a one for stuffing
    task automatic startPacket();
        level = 1'b1;
        onesRun = 0;
        for (int i = 0; i < 8; i++) begin
            rawBit(i == 7);
        end
    endtask

    // two SE0 bits followed by J and some idle
    task automatic finishPacket();
        driveLine(1'b0, 1'b0);
        driveLine(1'b0, 1'b0);
        repeat (3) driveLine(1'b1, 1'b0);
    endtask

    // x^5 + x^2 + 1 over the 11 field bits and sent inverted with the high term first
    function automatic logic [4:0] crc5Field(input logic [10:0] value);
        logic [4:0] c;
        logic [4:0] field;
        logic fb;
        c = 5'b11111;
        for (int i = 0; i < 11; i++) begin
            fb = c[4] ^ value[i];
            c = {c[3:0], 1'b0};
            if (fb) begin
                c = c ^ 5'b00101;
            end
        end
        for (int i = 0; i < 5; i++) begin
            field[i] = ~c[4 - i];
        end
        return field;
    endfunction

    task automatic sendToken(input usbPacketPkg::pid_t pid, input logic [10:0] value,
                             input logic breakCrc, input logic breakCheck);
        logic [4:0] crc;
        logic [7:0] pidByte;
        crc = crc5Field(value);
        if (breakCrc) begin
            crc = crc ^ 5'b00001;
        end
        pidByte = {~pid, pid};
        if (breakCheck) begin
            pidByte[7] = ~pidByte[7];
        end
        startPacket();
        encodeByte(pidByte);
        encodeByte(value[7:0]);
        encodeByte({crc, value[10:8]});
        finishPacket();
    endtask

    // good token with random address and endpoint
    task automatic expectToken(input usbPacketPkg::pid_t pid);
        logic [10:0] value;
        value = 11'($urandom);
        tokQ.push_back({1'b0, pid, value});
        sendToken(pid, value, 1'b0, 1'b0);
    endtask

    task automatic sendHandshake(input usbPacketPkg::pid_t pid);
        hsQ.push_back(pid);
        startPacket();
        encodeByte({~pid, pid});
        finishPacket();
    endtask

    // bytes 2 and 3 are 0xFF so stuffing shows up inside the payload
    task automatic sendData(input usbPacketPkg::pid_t pid, input int count, input logic flipCrc);
        logic [7:0] bytes[$];
        logic [7:0] b;
        logic [15:0] c;
        logic [15:0] field;
        logic fb;
        c = 16'hFFFF;
        for (int i = 0; i < count; i++) begin
            b = (i == 2 || i == 3) ? 8'hFF : 8'($urandom);
            bytes.push_back(b);
            dataQ.push_back(b);
            // x^16 + x^15 + x^2 + 1 taking the lsb of each byte first
            for (int j = 0; j < 8; j++) begin
                fb = c[15] ^ b[j];
                c = {c[14:0], 1'b0};
                if (fb) begin
                    c = c ^ 16'h8005;
                end
            end
        end
        for (int i = 0; i < 16; i++) begin
            field[i] = ~c[15 - i];
        end
        if (flipCrc) begin
            field[5] = ~field[5];
        end
        endQ.push_back(!flipCrc);
        startPacket();
        encodeByte({~pid, pid});
        for (int i = 0; i < count; i++) begin
            encodeByte(bytes[i]);
        end
        encodeByte(field[7:0]);
        encodeByte(field[15:8]);
        finishPacket();
    endtask

    // OUT pid then the line held still without a stuffed zero
    task automatic sendSevenOnes();
        errPending++;
        startPacket();
        encodeByte({~usbPacketPkg::PID_OUT, usbPacketPkg::PID_OUT});
        repeat (8) rawBit(1'b1);
        // the bit error comes out before any eop is on the line
        assert (errPending == 0) else begin
            $display("no packetError came out while seven ones were on the line");
            errorCount++;
        end
        finishPacket();
    endtask

    task automatic endTest(input string name);
        int waited;
        int pending;
        waited = 0;
        pending = tokQ.size() + hsQ.size() + dataQ.size() + endQ.size() + errPending;
        while (pending != 0 && waited < RESULT_WAIT) begin
            @(posedge CLK);
            waited++;
            pending = tokQ.size() + hsQ.size() + dataQ.size() + endQ.size() + errPending;
        end
        assert (pending == 0) else begin
            $display("%s: %0d expected results never came out", name, pending);
            errorCount++;
        end
        tokQ.delete();
        hsQ.delete();
        dataQ.delete();
        endQ.delete();
        errPending = 0;
        testIndex++;
        if (errorCount == testErrors) begin
            testsOk++;
            $display("test %0d %s: ok", testIndex, name);
        end else begin
            testsBad++;
            $display("test %0d %s: failed with %0d errors", testIndex, name,
                     errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    // outputs settle after the rising edge and are read half a cycle later
    always @(negedge CLK) begin : resultMonitor
        logic [15:0] tok;
        if (!rst && tokenValid) begin
            assert (tokQ.size() > 0) else begin
                $display("tokenValid pulsed at time %0t with no token sent", $time);
                errorCount++;
            end
            if (tokQ.size() > 0) begin
                tok = tokQ.pop_front();
                compareField("tokenPid", tok[14:11], tokenPid);
                if (tok[15]) begin
                    compareField("frameNumber", tok[10:0], frameNumber);
                end else begin
                    compareField("tokenAddr", tok[6:0], tokenAddr);
                    compareField("tokenEndp", tok[10:7], tokenEndp);
                end
            end
        end
        if (!rst && handshakeValid) begin
            assert (hsQ.size() > 0) else begin
                $display("handshakeValid pulsed at time %0t with no handshake sent", $time);
                errorCount++;
            end
            if (hsQ.size() > 0) begin
                compareField("handshakePid", hsQ.pop_front(), handshakePid);
            end
        end
        if (!rst && dataValid) begin
            assert (dataQ.size() > 0) else begin
                $display("dataValid pulsed at time %0t beyond the sent payload", $time);
                errorCount++;
            end
            if (dataQ.size() > 0) begin
                compareField("dataByte", dataQ.pop_front(), dataByte);
            end
        end
        if (!rst && dataEnd) begin
            assert (endQ.size() > 0) else begin
                $display("dataEnd pulsed at time %0t with no data packet open", $time);
                errorCount++;
            end
            if (endQ.size() > 0) begin
                compareField("crcOk", endQ.pop_front(), crcOk);
            end
        end
        if (!rst && packetError) begin
            assert (errPending > 0) else begin
                $display("packetError pulsed at time %0t on a good packet", $time);
                errorCount++;
            end
            if (errPending > 0) begin
                errPending--;
            end
        end
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        // idle J on the pins
        dpDrive = 1'b1;
        dnDrive = 1'b0;
        rst = 1'b1;
        level = 1'b1;
        onesRun = 0;
        errPending = 0;
        errorCount = 0;
        testErrors = 0;
        testIndex = 0;
        testsOk = 0;
        testsBad = 0;
        void'($urandom(46967));
        repeat (8) @(posedge CLK);
        #5;
        rst = 1'b0;
        @(negedge CLK);
        assert (!(tokenValid || handshakeValid || dataValid || dataEnd || packetError)) else begin
            $display("result pulse high right after reset");
            errorCount++;
        end
        compareField("usbPullup", 1'b1, usbPullup);
        repeat (4) driveLine(1'b1, 1'b0);

        expectToken(usbPacketPkg::PID_OUT);
        expectToken(usbPacketPkg::PID_IN);
        expectToken(usbPacketPkg::PID_SETUP);
        endTest("out/in/setup tokens");

        for (int i = 0; i < 2; i++) begin
            logic [10:0] frame;
            frame = 11'($urandom);
            tokQ.push_back({1'b1, usbPacketPkg::PID_SOF, frame});
            sendToken(usbPacketPkg::PID_SOF, frame, 1'b0, 1'b0);
        end
        endTest("sof frame number");

        sendHandshake(usbPacketPkg::PID_ACK);
        sendHandshake(usbPacketPkg::PID_NAK);
        sendHandshake(usbPacketPkg::PID_STALL);
        endTest("handshakes");

        sendData(usbPacketPkg::PID_DATA0, 8, 1'b0);
        sendData(usbPacketPkg::PID_DATA1, 8, 1'b0);
        // one crc16 bit flipped
        sendData(usbPacketPkg::PID_DATA0, 6, 1'b1);
        endTest("data packets");

        errPending = 2;
        sendToken(usbPacketPkg::PID_OUT, 11'($urandom), 1'b1, 1'b0);
        sendToken(usbPacketPkg::PID_IN, 11'($urandom), 1'b0, 1'b1);
        endTest("bad crc5 and pid check");

        sendSevenOnes();
        expectToken(usbPacketPkg::PID_SETUP);
        endTest("stuffing error and recovery");

        $display("results: %0d tests ok, %0d tests failing, %0d errors",
                 testsOk, testsBad, errorCount);
        if (testsBad == 0 && errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/usbLinePkg.sv
logic/usbPacketPkg.sv
logic/usbDp.sv
logic/usbBitReceiver.sv
logic/usbByteFifo.sv
logic/usbPacketDecoder.sv
logic/usb.sv
test/usbClock.sv
test/usbTb.sv
